/* all.f */
+incdir+test
source/pond_pkg.sv
source/loop_nest.sv
source/affine_addr_gen.sv
source/schedule_gen.sv
source/pond_memory.sv
source/pond_top.sv
test/tb_pond_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module tb_pond_top -f all.f -o tb_pond_top &&
  ./obj_dir/tb_pond_top > sim.log 2>&1 ||
  echo "build or simulation stopped early"
grep -q "Simulation finished: PASS" sim.log && echo "pond testbench passed" && exit 0
echo "pond testbench failed, see sim.log"
exit 1

/* source/affine_addr_gen.sv */
module affine_addr_gen
  import pond_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tile_en,
  input  logic      step,
  input  logic      restart,
  input  dim_sel_t  dim_sel,
  input  cfg_word_t start,
  input  cfg_vec_t  strides,
  output cfg_word_t addr
);

  cfg_word_t offset;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (tile_en && step) begin
      if (restart) begin
        offset <= '0;
      end else begin
        offset <= offset + strides[dim_sel];
      end
    end
  end

  // Wraps at 16 bits.
  assign addr = start + offset;

endmodule

/* source/loop_nest.sv */
module loop_nest
  import pond_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tile_en,
  input  logic       step,
  input  dim_count_t dimensionality,
  input  cfg_vec_t   ranges,
  output dim_sel_t   dim_sel,
  output logic       restart
);

  cfg_word_t dim_index [NUM_DIMS];
  logic [NUM_DIMS-1:0] can_step;
  logic found;
  logic advance;
  logic done_q;

  assign advance = tile_en & step;

  // A dimension can still step while it is active and below its range.
  always_comb begin
    for (int i = 0; i < NUM_DIMS; i++) begin
      can_step[i] = (dim_count_t'(i) < dimensionality) && (dim_index[i] != ranges[i]);
    end
  end

  // Lowest steppable dimension wins.
  always_comb begin
    dim_sel = '0;
    found = 1'b0;
    for (int i = NUM_DIMS - 1; i >= 0; i--) begin
      if (can_step[i]) begin
        dim_sel = dim_sel_t'(i);
        found = 1'b1;
      end
    end
  end

  for (genvar i = 0; i < NUM_DIMS; i++) begin : g_dim
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        dim_index[i] <= '0;
      end else if (advance && found) begin
        if (dim_sel == dim_sel_t'(i)) begin
          dim_index[i] <= dim_index[i] + 16'd1;
        end else if (dim_sel > dim_sel_t'(i)) begin
          // Inner dimensions wrap when an outer one steps.
          dim_index[i] <= '0;
        end
      end
    end
  end

  // A step with nothing left to advance was the last iteration.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (advance && !found) begin
      done_q <= 1'b1;
    end
  end

  assign restart = done_q;

endmodule

/* source/pond_memory.sv */
module pond_memory
  import pond_pkg::*;
(
  input  logic      clk,
  input  logic      write_en,
  input  mem_addr_t write_addr,
  input  data_t     write_data,
  input  mem_addr_t read_addr,
  output data_t     read_data
);

  data_t mem [MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  // Read is combinational, so a write shows up the cycle after.
  assign read_data = mem[read_addr];

endmodule

/* source/pond_pkg.sv */
package pond_pkg;

  localparam int NUM_DIMS = 6;
  localparam int CFG_WIDTH = 16;
  localparam int DATA_WIDTH = 16;
  localparam int MEM_DEPTH = 32;
  localparam int MEM_ADDR_WIDTH = 5;

  // One stored word.
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Ranges, strides, start values, running addresses and the cycle count.
  typedef logic [CFG_WIDTH-1:0] cfg_word_t;

  // One value per loop dimension, dimension 0 in the low bits.
  typedef logic [NUM_DIMS-1:0][CFG_WIDTH-1:0] cfg_vec_t;

  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // Index of a loop dimension.
  typedef logic [2:0] dim_sel_t;

  // Number of active dimensions.
  typedef logic [3:0] dim_count_t;

endpackage

/* source/pond_top.sv */
module pond_top
  import pond_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tile_en,
  input  data_t      data_in,
  output data_t      data_out,
  output logic       data_out_valid,
  input  dim_count_t wr_dimensionality,
  input  cfg_vec_t   wr_ranges,
  input  cfg_word_t  wr_addr_start,
  input  cfg_vec_t   wr_addr_strides,
  input  cfg_word_t  wr_sched_start,
  input  cfg_vec_t   wr_sched_strides,
  input  dim_count_t rd_dimensionality,
  input  cfg_vec_t   rd_ranges,
  input  cfg_word_t  rd_addr_start,
  input  cfg_vec_t   rd_addr_strides,
  input  cfg_word_t  rd_sched_start,
  input  cfg_vec_t   rd_sched_strides
);

  cfg_word_t cycle_count;

  dim_sel_t  wr_dim_sel;
  logic      wr_restart;
  cfg_word_t wr_addr;
  logic      write_en;

  dim_sel_t  rd_dim_sel;
  logic      rd_restart;
  cfg_word_t rd_addr;

  // Shared time base that freezes with the tile.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_count <= '0;
    end else if (tile_en) begin
      cycle_count <= cycle_count + 16'd1;
    end
  end

  // Write port.
  loop_nest wr_loop_nest (
    .clk            (clk),
    .rst_n          (rst_n),
    .tile_en        (tile_en),
    .step           (write_en),
    .dimensionality (wr_dimensionality),
    .ranges         (wr_ranges),
    .dim_sel        (wr_dim_sel),
    .restart        (wr_restart)
  );

  affine_addr_gen wr_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .tile_en (tile_en),
    .step    (write_en),
    .restart (wr_restart),
    .dim_sel (wr_dim_sel),
    .start   (wr_addr_start),
    .strides (wr_addr_strides),
    .addr    (wr_addr)
  );

  schedule_gen wr_sched_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .tile_en       (tile_en),
    .cycle_count   (cycle_count),
    .dim_sel       (wr_dim_sel),
    .finished      (wr_restart),
    .sched_start   (wr_sched_start),
    .sched_strides (wr_sched_strides),
    .access        (write_en)
  );

  // Read port.
  loop_nest rd_loop_nest (
    .clk            (clk),
    .rst_n          (rst_n),
    .tile_en        (tile_en),
    .step           (data_out_valid),
    .dimensionality (rd_dimensionality),
    .ranges         (rd_ranges),
    .dim_sel        (rd_dim_sel),
    .restart        (rd_restart)
  );

  affine_addr_gen rd_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .tile_en (tile_en),
    .step    (data_out_valid),
    .restart (rd_restart),
    .dim_sel (rd_dim_sel),
    .start   (rd_addr_start),
    .strides (rd_addr_strides),
    .addr    (rd_addr)
  );

  schedule_gen rd_sched_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .tile_en       (tile_en),
    .cycle_count   (cycle_count),
    .dim_sel       (rd_dim_sel),
    .finished      (rd_restart),
    .sched_start   (rd_sched_start),
    .sched_strides (rd_sched_strides),
    .access        (data_out_valid)
  );

  // Only the low address bits reach the 32-word array.
  pond_memory pond_mem (
    .clk        (clk),
    .write_en   (write_en),
    .write_addr (wr_addr[MEM_ADDR_WIDTH-1:0]),
    .write_data (data_in),
    .read_addr  (rd_addr[MEM_ADDR_WIDTH-1:0]),
    .read_data  (data_out)
  );

endmodule

/* source/schedule_gen.sv */
module schedule_gen
  import pond_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tile_en,
  input  cfg_word_t cycle_count,
  input  dim_sel_t  dim_sel,
  input  logic      finished,
  input  cfg_word_t sched_start,
  input  cfg_vec_t  sched_strides,
  output logic      access
);

  cfg_word_t sched_cycle;
  logic gate_closed;
  logic gate_open;

  // Finished blocks the very next cycle too, before the flop has latched it.
  assign gate_open = !gate_closed && !finished;

  assign access = tile_en && gate_open && (sched_cycle == cycle_count);

  // Stays closed until reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gate_closed <= 1'b0;
    end else if (tile_en && finished) begin
      gate_closed <= 1'b1;
    end
  end

  // Next scheduled cycle, same affine walk as the address.
  affine_addr_gen u_sched_addr (
    .clk     (clk),
    .rst_n   (rst_n),
    .tile_en (tile_en),
    .step    (access),
    .restart (1'b0),
    .dim_sel (dim_sel),
    .start   (sched_start),
    .strides (sched_strides),
    .addr    (sched_cycle)
  );

endmodule

/* test/tb_pond_cases.svh */
`ifndef TB_POND_CASES_SVH
`define TB_POND_CASES_SVH

typedef struct {
  dim_count_t wr_dims;
  cfg_vec_t   wr_ranges;
  cfg_word_t  wr_addr_start;
  cfg_vec_t   wr_addr_strides;
  cfg_word_t  wr_sched_start;
  cfg_vec_t   wr_sched_strides;
  dim_count_t rd_dims;
  cfg_vec_t   rd_ranges;
  cfg_word_t  rd_addr_start;
  cfg_vec_t   rd_addr_strides;
  cfg_word_t  rd_sched_start;
  cfg_vec_t   rd_sched_strides;
  int         pause_start;
  int         pause_len;
  int         exp_reads;
} pond_case_t;

localparam int NUM_CASES = 7;

pond_case_t case_table [NUM_CASES];

// Dimensions 3 to 5 stay zero.
function automatic cfg_vec_t per_dim(input cfg_word_t d0, input cfg_word_t d1,
                                     input cfg_word_t d2);
  cfg_vec_t v;
  v = '0;
  v[0] = d0;
  v[1] = d1;
  v[2] = d2;
  return v;
endfunction

// Each row is write dims, ranges, addr start, addr strides, sched start, sched strides,
// the same six for the read port, then pause start, pause length and expected reads.
task automatic load_cases();
  case_table[0] = '{4'd1, per_dim(16'd7, 16'd0, 16'd0), 16'd0, per_dim(16'd1, 16'd0, 16'd0),
    16'd0, per_dim(16'd1, 16'd0, 16'd0),
    4'd1, per_dim(16'd7, 16'd0, 16'd0), 16'd0, per_dim(16'd1, 16'd0, 16'd0),
    16'd10, per_dim(16'd1, 16'd0, 16'd0), 0, 0, 8};
  // Row-major write, column-major read.
  case_table[1] = '{4'd2, per_dim(16'd3, 16'd3, 16'd0), 16'd8, per_dim(16'd1, 16'd1, 16'd0),
    16'd0, per_dim(16'd1, 16'd1, 16'd0),
    4'd2, per_dim(16'd3, 16'd3, 16'd0), 16'd8, per_dim(16'd4, 16'hfff5, 16'd0),
    16'd20, per_dim(16'd1, 16'd1, 16'd0), 0, 0, 16};
  case_table[2] = '{4'd1, per_dim(16'd9, 16'd0, 16'd0), 16'd16, per_dim(16'd1, 16'd0, 16'd0),
    16'd0, per_dim(16'd2, 16'd0, 16'd0),
    4'd1, per_dim(16'd9, 16'd0, 16'd0), 16'd16, per_dim(16'd1, 16'd0, 16'd0),
    16'd2, per_dim(16'd2, 16'd0, 16'd0), 0, 0, 10};
  case_table[3] = '{4'd2, per_dim(16'd3, 16'd1, 16'd0), 16'd0, per_dim(16'd1, 16'd1, 16'd0),
    16'd0, per_dim(16'd1, 16'd1, 16'd0),
    4'd1, per_dim(16'd7, 16'd0, 16'd0), 16'd0, per_dim(16'd1, 16'd0, 16'd0),
    16'd4, per_dim(16'd1, 16'd0, 16'd0), 6, 5, 8};
  // Addresses 32 to 35 land on words 0 to 3.
  case_table[4] = '{4'd3, per_dim(16'd1, 16'd1, 16'd1), 16'd28, per_dim(16'd1, 16'd1, 16'd1),
    16'd0, per_dim(16'd1, 16'd1, 16'd1),
    4'd3, per_dim(16'd1, 16'd1, 16'd1), 16'd28, per_dim(16'd2, 16'hffff, 16'd1),
    16'd12, per_dim(16'd1, 16'd2, 16'd3), 0, 0, 8};
  // Cut short after five of sixteen reads.
  case_table[5] = '{4'd1, per_dim(16'd15, 16'd0, 16'd0), 16'd0, per_dim(16'd1, 16'd0, 16'd0),
    16'd0, per_dim(16'd1, 16'd0, 16'd0),
    4'd1, per_dim(16'd15, 16'd0, 16'd0), 16'd0, per_dim(16'd1, 16'd0, 16'd0),
    16'd3, per_dim(16'd1, 16'd0, 16'd0), 0, 0, 5};
  case_table[6] = '{4'd1, per_dim(16'd3, 16'd0, 16'd0), 16'd4, per_dim(16'd1, 16'd0, 16'd0),
    16'd0, per_dim(16'd1, 16'd0, 16'd0),
    4'd1, per_dim(16'd5, 16'd0, 16'd0), 16'd2, per_dim(16'd1, 16'd0, 16'd0),
    16'd0, per_dim(16'd1, 16'd0, 16'd0), 0, 0, 6};
endtask

`endif

/* test/tb_pond_top.sv */
module tb_pond_top
  import pond_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int CASE_TIMEOUT = 200;
  localparam int TAIL_CYCLES = 50;
  localparam int MAX_ACCESSES = 1024;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       tile_en;
  data_t      data_in;
  data_t      data_out;
  logic       data_out_valid;
  dim_count_t wr_dimensionality;
  cfg_vec_t   wr_ranges;
  cfg_word_t  wr_addr_start;
  cfg_vec_t   wr_addr_strides;
  cfg_word_t  wr_sched_start;
  cfg_vec_t   wr_sched_strides;
  dim_count_t rd_dimensionality;
  cfg_vec_t   rd_ranges;
  cfg_word_t  rd_addr_start;
  cfg_vec_t   rd_addr_strides;
  cfg_word_t  rd_sched_start;
  cfg_vec_t   rd_sched_strides;

  // Software copy of the array, which keeps its contents across resets.
  data_t     model_mem [MEM_DEPTH];
  logic      known [MEM_DEPTH];
  cfg_word_t wr_addr_q [$];
  cfg_word_t wr_sched_q [$];
  cfg_word_t rd_addr_q [$];
  cfg_word_t rd_sched_q [$];
  cfg_word_t sw_cycle;
  int        wr_k;
  int        rd_k;
  int        rd_seen;
  logic      cur_en;
  data_t     cur_data;
  logic [31:0] rng_state;
  int        value_errors = 0;
  int        timeouts = 0;

  `include "tb_pond_cases.svh"

  always #4 clk = ~clk;

  pond_top u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .tile_en           (tile_en),
    .data_in           (data_in),
    .data_out          (data_out),
    .data_out_valid    (data_out_valid),
    .wr_dimensionality (wr_dimensionality),
    .wr_ranges         (wr_ranges),
    .wr_addr_start     (wr_addr_start),
    .wr_addr_strides   (wr_addr_strides),
    .wr_sched_start    (wr_sched_start),
    .wr_sched_strides  (wr_sched_strides),
    .rd_dimensionality (rd_dimensionality),
    .rd_ranges         (rd_ranges),
    .rd_addr_start     (rd_addr_start),
    .rd_addr_strides   (rd_addr_strides),
    .rd_sched_start    (rd_sched_start),
    .rd_sched_strides  (rd_sched_strides)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t next_data();
    rng_state = xorshift(rng_state);
    return rng_state[DATA_WIDTH-1:0];
  endfunction

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_count(input string name, input cfg_word_t got, input cfg_word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
    end
  endtask

  // Walks the loop nest and lists every access as an address and a cycle.
  task automatic build_pattern(input logic is_read, input dim_count_t dims,
                               input cfg_vec_t ranges, input cfg_word_t a_start,
                               input cfg_vec_t a_strides, input cfg_word_t s_start,
                               input cfg_vec_t s_strides);
    int idx [NUM_DIMS];
    int d;
    int count;
    cfg_word_t a;
    cfg_word_t s;
    for (int i = 0; i < NUM_DIMS; i++) begin
      idx[i] = 0;
    end
    a = a_start;
    s = s_start;
    count = 0;
    d = 0;
    while (d >= 0 && count < MAX_ACCESSES) begin
      if (is_read) begin
        rd_addr_q.push_back(a);
        rd_sched_q.push_back(s);
      end else begin
        wr_addr_q.push_back(a);
        wr_sched_q.push_back(s);
      end
      count++;
      d = -1;
      for (int i = NUM_DIMS - 1; i >= 0; i--) begin
        if (i < int'(dims) && idx[i] != int'(ranges[i])) begin
          d = i;
        end
      end
      if (d >= 0) begin
        idx[d] = idx[d] + 1;
        for (int j = 0; j < d; j++) begin
          idx[j] = 0;
        end
        a = a + a_strides[d];
        s = s + s_strides[d];
      end
    end
  endtask

  task automatic init_inputs();
    rst_n <= 1'b0;
    tile_en <= 1'b0;
    data_in <= '0;
    wr_dimensionality <= '0;
    wr_ranges <= '0;
    wr_addr_start <= '0;
    wr_addr_strides <= '0;
    wr_sched_start <= '0;
    wr_sched_strides <= '0;
    rd_dimensionality <= '0;
    rd_ranges <= '0;
    rd_addr_start <= '0;
    rd_addr_strides <= '0;
    rd_sched_start <= '0;
    rd_sched_strides <= '0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      known[i] = 1'b0;
      model_mem[i] = '0;
    end
    rng_state = 32'd27;
    cur_en = 1'b0;
    cur_data = '0;
    sw_cycle = '0;
    wr_k = 0;
    rd_k = 0;
  endtask

  task automatic drive_config(input int c);
    wr_dimensionality <= case_table[c].wr_dims;
    wr_ranges <= case_table[c].wr_ranges;
    wr_addr_start <= case_table[c].wr_addr_start;
    wr_addr_strides <= case_table[c].wr_addr_strides;
    wr_sched_start <= case_table[c].wr_sched_start;
    wr_sched_strides <= case_table[c].wr_sched_strides;
    rd_dimensionality <= case_table[c].rd_dims;
    rd_ranges <= case_table[c].rd_ranges;
    rd_addr_start <= case_table[c].rd_addr_start;
    rd_addr_strides <= case_table[c].rd_addr_strides;
    rd_sched_start <= case_table[c].rd_sched_start;
    rd_sched_strides <= case_table[c].rd_sched_strides;
  endtask

  // Lands the scheduled write of the cycle that just ended in the model.
  task automatic close_cycle();
    cfg_word_t full_addr;
    mem_addr_t addr;
    if (cur_en) begin
      if (wr_k < wr_sched_q.size()) begin
        if (wr_sched_q[wr_k] == sw_cycle) begin
          full_addr = wr_addr_q[wr_k];
          addr = full_addr[MEM_ADDR_WIDTH-1:0];
          model_mem[addr] = cur_data;
          known[addr] = 1'b1;
          wr_k++;
        end
      end
      sw_cycle = sw_cycle + 16'd1;
    end
  endtask

  task automatic check_outputs();
    logic exp_valid;
    cfg_word_t full_addr;
    mem_addr_t addr;
    exp_valid = 1'b0;
    if (cur_en && rd_k < rd_sched_q.size()) begin
      exp_valid = (rd_sched_q[rd_k] == sw_cycle);
    end
    if (data_out_valid === 1'b1) begin
      rd_seen++;
    end
    check_valid("data_out_valid", data_out_valid, exp_valid);
    if (exp_valid) begin
      full_addr = rd_addr_q[rd_k];
      addr = full_addr[MEM_ADDR_WIDTH-1:0];
      if (known[addr]) begin
        check_data("data_out", data_out, model_mem[addr]);
      end
      rd_k++;
    end
  endtask

  task automatic apply_reset(input int c);
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      close_cycle();
      cur_en = 1'b0;
      cur_data = next_data();
      rst_n <= 1'b0;
      tile_en <= 1'b0;
      data_in <= cur_data;
      drive_config(c);
      @(negedge clk);
      check_valid("data_out_valid", data_out_valid, 1'b0);
    end
    wr_addr_q.delete();
    wr_sched_q.delete();
    rd_addr_q.delete();
    rd_sched_q.delete();
    build_pattern(1'b0, case_table[c].wr_dims, case_table[c].wr_ranges,
                  case_table[c].wr_addr_start, case_table[c].wr_addr_strides,
                  case_table[c].wr_sched_start, case_table[c].wr_sched_strides);
    build_pattern(1'b1, case_table[c].rd_dims, case_table[c].rd_ranges,
                  case_table[c].rd_addr_start, case_table[c].rd_addr_strides,
                  case_table[c].rd_sched_start, case_table[c].rd_sched_strides);
    sw_cycle = '0;
    wr_k = 0;
    rd_k = 0;
    rd_seen = 0;
  endtask

  // Runs cycle t after reset release and applies the case's pause window.
  task automatic step_cycle(input int c, input int t);
    logic en;
    @(posedge clk);
    close_cycle();
    en = !(t >= case_table[c].pause_start &&
           t < case_table[c].pause_start + case_table[c].pause_len);
    cur_en = en;
    cur_data = next_data();
    rst_n <= 1'b1;
    tile_en <= en;
    data_in <= cur_data;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic run_case(input int c);
    int t;
    apply_reset(c);
    t = 0;
    while (rd_seen < case_table[c].exp_reads && t < CASE_TIMEOUT) begin
      step_cycle(c, t);
      t++;
    end
    if (rd_seen < case_table[c].exp_reads) begin
      timeouts++;
      $display("case %0d timed out after %0d cycles with %0d of %0d reads", c, t, rd_seen,
               case_table[c].exp_reads);
    end
    // A complete case must stay quiet afterwards.
    if (case_table[c].exp_reads >= rd_sched_q.size()) begin
      for (int i = 0; i < TAIL_CYCLES; i++) begin
        step_cycle(c, t + i);
      end
      check_count("read count", cfg_word_t'(rd_seen), cfg_word_t'(case_table[c].exp_reads));
    end
  endtask

  initial begin
    init_inputs();
    load_cases();
    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end
    $display("%0d value errors, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
